/* tft_spi.f */
verilog/tft_spi_pkg.sv
verilog/tft_bus_regs.sv
verilog/tft_cmd_fifo.sv
verilog/tft_sck_gen.sv
verilog/tft_spi_tx.sv
verilog/tft_spi_top.sv
tests/tft_spi_checker.sv
tests/tft_spi_tb.sv

/* Makefile */
SIM        := verilator
TOP        := tft_spi_tb
FILELIST   := tft_spi.f
FLAGS      := --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tft_spi_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_spi_tb;

  logic        clk;
  logic        rst_n_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic        wb_ack_o;
  logic [31:0] wb_dat_o;
  logic        spi_req_o;
  logic        spi_ack_i;
  logic        spi_done_o;
  logic        sck_o;
  logic        dc_o;
  logic        sdo_o;
  logic        cs_n_o;

  // Frames packed as {dc, bit count, value}
  logic [22:0] exp_q[$];
  logic [22:0] rx_q[$];
  string       test_name = "setup";
  int          errors = 0;
  int          timeouts = 0;
  int          done_count = 0;
  int          frame_count = 0;
  int          writes_done = 0;
  bit          grant_hold = 1'b0;
  bit          run_done = 1'b0;
  logic [31:0] rd_data;
  logic [15:0] rx_shift = '0;
  int          rx_bits = 0;
  logic        rx_dc = 1'b1;
  logic        cs_prev = 1'b1;
  logic        sck_prev = 1'b0;
  logic        req_prev = 1'b0;

  tft_spi_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [22:0] expected_frame(input logic is_cmd, input logic [31:0] payload);
    logic [5:0]  nbits;
    logic [15:0] value;
    nbits = is_cmd ? 6'(tft_spi_pkg::CMD_BITS) : 6'(tft_spi_pkg::DATA_W);
    value = is_cmd ? 16'(payload[tft_spi_pkg::CMD_BITS-1:0]) : payload[15:0];  // MSB first
    return {~is_cmd, nbits, value};
  endfunction

  task automatic end_run();
    run_done = 1'b1;
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("Timeout in test %s while waiting for %s", test_name, what);
    timeouts++;
    end_run();
  endtask

  task automatic report_mismatch(input string what,
                                 input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s in test %s", msg, test_name);
    errors++;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic bus_access(input logic we, input logic [29:0] idx, input logic [31:0] data);
    int wait_cycles;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {idx, 2'b00};
    wb_dat_i = data;
    wait_cycles = 0;
    do
    begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 3000)
      begin
        timed_out("Wishbone ack");
      end
    end
    while (!wb_ack_o);
    rd_data = wb_dat_o;
    @(posedge clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic queue_write(input logic is_cmd, input logic [31:0] payload);
    exp_q.push_back(expected_frame(is_cmd, payload));
    bus_access(1'b1, is_cmd ? tft_spi_pkg::REG_CMD : tft_spi_pkg::REG_DATA, payload);
    writes_done++;
  endtask

  task automatic wait_frames_done();
    int wait_cycles;
    wait_cycles = 0;
    while (exp_q.size() != 0 || spi_req_o)
    begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 10000)
      begin
        timed_out("all frames to drain");
      end
    end
    @(posedge clk);
    #1;
  endtask

  // Arbiter model with a random grant delay
  initial
  begin : arbiter
    int delay;
    int wait_cycles;
    while (!run_done)
    begin
      @(negedge clk);
      if (spi_req_o && !spi_ack_i)
      begin
        delay = $urandom_range(20, 0);
        wait_cycles = 0;
        while (grant_hold || delay > 0)
        begin
          @(negedge clk);
          if (!grant_hold)
          begin
            delay--;
          end
          wait_cycles++;
          if (wait_cycles > 3000)
          begin
            timed_out("grant release");
          end
        end
        @(posedge clk);
        #1;
        spi_ack_i = 1'b1;
        wait_cycles = 0;
        do
        begin
          @(negedge clk);
          wait_cycles++;
          if (wait_cycles > 3000)
          begin
            timed_out("spi_done_o");
          end
        end
        while (!spi_done_o);
        @(posedge clk);
        #1;
        spi_ack_i = 1'b0;
      end
    end
  end

  // Serial receiver and pin protocol monitor
  always @(negedge clk)
  begin
    if (rst_n_i)
    begin
      if (!cs_n_o && !spi_ack_i)
        report_fault("Chip select low without a bus grant");
      if (sck_o && cs_n_o)
        report_fault("SCK high outside chip select");
      if (req_prev && !spi_req_o && !spi_done_o)
        report_fault("Bus request dropped before spi_done_o");
      if (spi_done_o)
        done_count++;
      if (cs_prev && !cs_n_o)
      begin
        rx_bits  = 0;
        rx_shift = '0;
        rx_dc    = dc_o;
      end
      if (!sck_prev && sck_o && !cs_n_o)
      begin
        rx_shift = {rx_shift[14:0], sdo_o};
        rx_bits++;
      end
      if (!cs_prev && cs_n_o)
      begin
        if (dc_o != rx_dc)
          report_fault("dc_o changed during a frame");
        rx_q.push_back({rx_dc, 6'(rx_bits), rx_shift});
        frame_count++;
      end
    end
    cs_prev  = cs_n_o;
    sck_prev = sck_o;
    req_prev = spi_req_o;
  end

  initial
  begin : compare_frames
    logic [22:0] got;
    logic [22:0] want;
    while (!run_done)
    begin
      @(negedge clk);
      if (rx_q.size() != 0)
      begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0)
        begin
          report_fault("Frame received with none expected");
        end
        else
        begin
          want = exp_q.pop_front();
          if (got[22] != want[22])
            report_mismatch("dc", 32'(want[22]), 32'(got[22]));
          if (got[21:16] != want[21:16])
            report_mismatch("bit count", 32'(want[21:16]), 32'(got[21:16]));
          if (got[15:0] != want[15:0])
            report_mismatch("value", 32'(want[15:0]), 32'(got[15:0]));
        end
      end
    end
  end

  initial
  begin : main_seq
    int i;
    int fc;
    void'($urandom(84));
    rst_n_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    spi_ack_i = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    test_name = "reset";
    @(negedge clk);
    if (cs_n_o !== 1'b1) report_mismatch("cs_n_o", 32'd1, 32'(cs_n_o));
    if (dc_o !== 1'b1) report_mismatch("dc_o", 32'd1, 32'(dc_o));
    if (sck_o !== 1'b0) report_mismatch("sck_o", 32'd0, 32'(sck_o));
    if (spi_req_o !== 1'b0) report_mismatch("spi_req_o", 32'd0, 32'(spi_req_o));
    if (wb_ack_o !== 1'b0) report_mismatch("wb_ack_o", 32'd0, 32'(wb_ack_o));
    @(posedge clk);
    #1;
    bus_access(1'b0, tft_spi_pkg::REG_STATUS, 32'd0);
    if (rd_data !== 32'h2) report_mismatch("status", 32'h2, rd_data);  // Idle set and full clear

    test_name = "command";
    queue_write(1'b1, $urandom);
    wait_frames_done();

    test_name = "data";
    queue_write(1'b0, $urandom);
    wait_frames_done();

    test_name = "arbitration";
    for (i = 0; i < 4; i++)
      queue_write(1'($urandom_range(1, 0)), $urandom);
    wait_frames_done();

    test_name = "back-pressure";
    grant_hold  = 1'b1;
    writes_done = 0;
    for (i = 0; i < tft_spi_pkg::FIFO_DEPTH; i++)
      queue_write(1'($urandom_range(1, 0)), $urandom);
    bus_access(1'b0, tft_spi_pkg::REG_STATUS, 32'd0);
    if (rd_data[0] !== 1'b1) report_mismatch("status full", 32'd1, 32'(rd_data[0]));
    fork
      begin
        for (int j = tft_spi_pkg::FIFO_DEPTH; j < 24; j++)
          queue_write(1'($urandom_range(1, 0)), $urandom);
      end
      begin
        repeat (50) @(negedge clk);
        if (writes_done != tft_spi_pkg::FIFO_DEPTH)
          report_mismatch("accepted writes", 32'(tft_spi_pkg::FIFO_DEPTH), 32'(writes_done));
        @(posedge clk);
        #1;
        grant_hold = 1'b0;
      end
    join
    wait_frames_done();

    test_name = "unmapped";
    fc = frame_count;
    bus_access(1'b1, tft_spi_pkg::REG_STATUS, $urandom);
    bus_access(1'b1, 30'h3, $urandom);
    bus_access(1'b1, 30'h100, $urandom);
    repeat (100) @(negedge clk);
    if (frame_count != fc) report_mismatch("frames", 32'(fc), 32'(frame_count));
    if (spi_req_o) report_fault("Bus request raised by a dropped write");

    test_name = "summary";
    if (done_count != frame_count)
      report_mismatch("done pulses", 32'(frame_count), 32'(done_count));
    end_run();
  end

endmodule

`default_nettype wire

/* tests/tft_spi_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_spi_checker (
  input wire clk,
  input wire rst_n_i,
  input wire wb_cyc_i,
  input wire wb_stb_i,
  input wire wb_ack_i,
  input wire spi_req_i,
  input wire spi_ack_i,
  input wire spi_done_i,
  input wire cs_n_i,
  input wire sck_i
);

  // Chip select only drops inside a granted request
  cs_fall_granted: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(cs_n_i) |-> spi_req_i && spi_ack_i)
    else $error("cs_n fell without request and grant");

  done_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    spi_done_i |=> !spi_done_i)
    else $error("spi_done longer than one cycle");

  done_with_cs: assert property (@(posedge clk) disable iff (!rst_n_i)
    spi_done_i |-> $rose(cs_n_i))
    else $error("spi_done without cs_n rising");

  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_ack_i |-> wb_cyc_i && wb_stb_i)
    else $error("wb_ack outside a bus cycle");

  ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack in two consecutive cycles");

  // Full low half-period before every SCK rise
  sck_low_half: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(sck_i) |-> !$past(sck_i, tft_spi_pkg::SCK_DIV))
    else $error("SCK low half-period too short");

endmodule

bind tft_spi_top tft_spi_checker chk_i (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .wb_cyc_i   (wb_cyc_i),
  .wb_stb_i   (wb_stb_i),
  .wb_ack_i   (wb_ack_o),
  .spi_req_i  (spi_req_o),
  .spi_ack_i  (spi_ack_i),
  .spi_done_i (spi_done_o),
  .cs_n_i     (cs_n_o),
  .sck_i      (sck_o)
);

`default_nettype wire

/* verilog/tft_spi_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_spi_top (
  input  wire         clk,
  input  wire         rst_n_i,

  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire         wb_we_i,
  input  wire  [31:0] wb_adr_i,
  input  wire  [31:0] wb_dat_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o,

  output logic        spi_req_o,
  input  wire         spi_ack_i,
  output logic        spi_done_o,
  output logic        sck_o,
  output logic        dc_o,
  output logic        sdo_o,
  output logic        cs_n_o
);

  logic                            fifo_full;
  logic                            fifo_empty;
  logic                            push;
  logic [tft_spi_pkg::ENTRY_W-1:0] push_entry;
  logic [tft_spi_pkg::ENTRY_W-1:0] head_entry;
  logic                            pop;
  logic                            tx_idle;
  logic                            sck_en;
  logic                            sck_rise;
  logic                            sck_fall;

  tft_bus_regs regs_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .fifo_full_i  (fifo_full),
    .tx_idle_i    (tx_idle),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .push_o       (push),
    .push_entry_o (push_entry)
  );

  tft_cmd_fifo fifo_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .head_entry_o (head_entry),
    .empty_o      (fifo_empty),
    .full_o       (fifo_full)
  );

  tft_sck_gen sck_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .sck_en_i   (sck_en),
    .sck_o      (sck_o),
    .sck_rise_o (sck_rise),
    .sck_fall_o (sck_fall)
  );

  tft_spi_tx tx_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fifo_empty_i (fifo_empty),
    .head_entry_i (head_entry),
    .spi_ack_i    (spi_ack_i),
    .sck_rise_i   (sck_rise),
    .sck_fall_i   (sck_fall),
    .pop_o        (pop),
    .sck_en_o     (sck_en),
    .spi_req_o    (spi_req_o),
    .spi_done_o   (spi_done_o),
    .cs_n_o       (cs_n_o),
    .dc_o         (dc_o),
    .sdo_o        (sdo_o),
    .tx_idle_o    (tx_idle)
  );

endmodule

`default_nettype wire

/* verilog/tft_spi_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_spi_tx (
  input  wire                              clk,
  input  wire                              rst_n_i,
  input  wire                              fifo_empty_i,
  input  wire  [tft_spi_pkg::ENTRY_W-1:0]  head_entry_i,
  input  wire                              spi_ack_i,
  input  wire                              sck_rise_i,
  input  wire                              sck_fall_i,
  output logic                             pop_o,
  output logic                             sck_en_o,
  output logic                             spi_req_o,
  output logic                             spi_done_o,
  output logic                             cs_n_o,
  output logic                             dc_o,
  output logic                             sdo_o,
  output logic                             tx_idle_o
);

  logic [2:0]                         state;
  logic [tft_spi_pkg::DATA_W-1:0]     shreg;
  logic [tft_spi_pkg::DATA_W-1:0]     load_word;
  logic [tft_spi_pkg::TX_CNT_W-1:0]   bit_cnt;
  logic                               head_cmd;

  assign head_cmd = head_entry_i[tft_spi_pkg::ENTRY_W-1];

  // Left-align so the MSB of either frame size leaves first
  assign load_word = head_cmd ?
    {head_entry_i[tft_spi_pkg::CMD_BITS-1:0],
     {(tft_spi_pkg::DATA_W - tft_spi_pkg::CMD_BITS){1'b0}}} :
    head_entry_i[tft_spi_pkg::DATA_W-1:0];

  assign pop_o     = spi_done_o;
  assign tx_idle_o = (state == tft_spi_pkg::TX_IDLE);

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state      <= tft_spi_pkg::TX_IDLE;
      spi_req_o  <= 1'b0;
      spi_done_o <= 1'b0;
      cs_n_o     <= 1'b1;
      dc_o       <= 1'b1;
      sdo_o      <= 1'b0;
      sck_en_o   <= 1'b0;
      bit_cnt    <= '0;
    end
    else
    begin
      spi_done_o <= 1'b0;

      case (state)
        tft_spi_pkg::TX_IDLE:
        begin
          // Empty flag lags the pop by a cycle
          if (!fifo_empty_i && !pop_o)
          begin
            spi_req_o <= 1'b1;
            state     <= tft_spi_pkg::TX_REQ;
          end
        end

        tft_spi_pkg::TX_REQ:
        begin
          if (spi_ack_i)
          begin
            cs_n_o   <= 1'b0;
            dc_o     <= ~head_cmd;
            sdo_o    <= load_word[tft_spi_pkg::DATA_W-1];
            bit_cnt  <= head_cmd ? tft_spi_pkg::CMD_LEN : tft_spi_pkg::DATA_LEN;
            sck_en_o <= 1'b1;
            state    <= tft_spi_pkg::TX_SELECT;
          end
        end

        tft_spi_pkg::TX_SELECT:
        begin
          if (sck_rise_i)  // First bit sampled
          begin
            bit_cnt <= bit_cnt - 1'b1;
            state   <= tft_spi_pkg::TX_SHIFT;
          end
        end

        tft_spi_pkg::TX_SHIFT:
        begin
          if (sck_rise_i)
          begin
            bit_cnt <= bit_cnt - 1'b1;
          end
          if (sck_fall_i)
          begin
            if (bit_cnt == '0)
            begin
              sck_en_o <= 1'b0;
              sdo_o    <= 1'b0;
              bit_cnt  <= tft_spi_pkg::HOLD_LEN;  // Counts out the last low half
              state    <= tft_spi_pkg::TX_RELEASE;
            end
            else
            begin
              sdo_o <= shreg[tft_spi_pkg::DATA_W-1];
            end
          end
        end

        tft_spi_pkg::TX_RELEASE:
        begin
          if (bit_cnt == '0)
          begin
            cs_n_o     <= 1'b1;
            spi_req_o  <= 1'b0;
            spi_done_o <= 1'b1;
            state      <= tft_spi_pkg::TX_IDLE;
          end
          else
          begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        default:
        begin
          state <= tft_spi_pkg::TX_IDLE;
        end
      endcase
    end
  end

  // Bits still to go, MSB next
  always_ff @(posedge clk)
  begin
    if (state == tft_spi_pkg::TX_REQ && spi_ack_i)
    begin
      shreg <= {load_word[tft_spi_pkg::DATA_W-2:0], 1'b0};
    end
    else if (state == tft_spi_pkg::TX_SHIFT && sck_fall_i)
    begin
      shreg <= {shreg[tft_spi_pkg::DATA_W-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* verilog/tft_sck_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_sck_gen (
  input  wire  clk,
  input  wire  rst_n_i,
  input  wire  sck_en_i,
  output logic sck_o,
  output logic sck_rise_o,
  output logic sck_fall_o
);

  logic [tft_spi_pkg::SCK_CNT_W-1:0] cnt;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      cnt        <= '0;
      sck_o      <= 1'b0;
      sck_rise_o <= 1'b0;
      sck_fall_o <= 1'b0;
    end
    else
    begin
      sck_rise_o <= 1'b0;
      sck_fall_o <= 1'b0;

      if (!sck_en_i)
      begin
        cnt   <= '0;
        sck_o <= 1'b0;  // Parked low, next frame starts with a full low half
      end
      else if (cnt == tft_spi_pkg::SCK_LAST)
      begin
        cnt        <= '0;
        sck_o      <= ~sck_o;
        sck_rise_o <= ~sck_o;  // Strobe lines up with the new SCK level
        sck_fall_o <= sck_o;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/tft_cmd_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_cmd_fifo (
  input  wire                              clk,
  input  wire                              rst_n_i,
  input  wire                              push_i,
  input  wire  [tft_spi_pkg::ENTRY_W-1:0]  push_entry_i,
  input  wire                              pop_i,
  output logic [tft_spi_pkg::ENTRY_W-1:0]  head_entry_o,
  output logic                             empty_o,
  output logic                             full_o
);

  logic [tft_spi_pkg::ENTRY_W-1:0] mem [tft_spi_pkg::FIFO_DEPTH];

  // Pointers carry one extra wrap bit
  logic [tft_spi_pkg::FIFO_AW:0] wr_ptr;
  logic [tft_spi_pkg::FIFO_AW:0] rd_ptr;
  logic [tft_spi_pkg::FIFO_AW:0] count;
  logic                          do_push;
  logic                          do_pop;

  assign count   = wr_ptr - rd_ptr;
  assign empty_o = (count == '0);
  assign full_o  = count[tft_spi_pkg::FIFO_AW];  // Only set at FIFO_DEPTH

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // First-word fall-through head
  assign head_entry_o = mem[rd_ptr[tft_spi_pkg::FIFO_AW-1:0]];

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr[tft_spi_pkg::FIFO_AW-1:0]] <= push_entry_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/tft_bus_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tft_bus_regs (
  input  wire                                clk,
  input  wire                                rst_n_i,
  input  wire                                wb_cyc_i,
  input  wire                                wb_stb_i,
  input  wire                                wb_we_i,
  input  wire  [31:0]                        wb_adr_i,
  input  wire  [31:0]                        wb_dat_i,
  input  wire                                fifo_full_i,
  input  wire                                tx_idle_i,
  output logic                               wb_ack_o,
  output logic [31:0]                        wb_dat_o,
  output logic                               push_o,
  output logic [tft_spi_pkg::ENTRY_W-1:0]    push_entry_o
);

  logic [29:0] word_idx;
  logic        req_valid;
  logic        is_cmd;
  logic        is_data;
  logic        is_status;
  logic        pending_q;

  assign word_idx  = wb_adr_i[31:2];
  assign is_cmd    = (word_idx == tft_spi_pkg::REG_CMD);
  assign is_data   = (word_idx == tft_spi_pkg::REG_DATA);
  assign is_status = (word_idx == tft_spi_pkg::REG_STATUS);

  // No new request in the ack cycle, nor while a write waits for space
  assign req_valid = wb_cyc_i && wb_stb_i && !wb_ack_o && !pending_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wb_ack_o  <= 1'b0;
      push_o    <= 1'b0;
      pending_q <= 1'b0;
    end
    else
    begin
      wb_ack_o <= 1'b0;
      push_o   <= 1'b0;

      if (pending_q)
      begin
        // Held write goes out once the FIFO has room
        if (!fifo_full_i)
        begin
          wb_ack_o  <= 1'b1;
          push_o    <= 1'b1;
          pending_q <= 1'b0;
        end
      end
      else if (req_valid)
      begin
        if (wb_we_i && (is_cmd || is_data))
        begin
          if (fifo_full_i)
          begin
            pending_q <= 1'b1;  // Stall the master, ack comes later
          end
          else
          begin
            wb_ack_o <= 1'b1;
            push_o   <= 1'b1;
          end
        end
        else
        begin
          wb_ack_o <= 1'b1;  // Reads, status writes and unmapped writes
        end
      end
    end
  end

  // Entry register doubles as the pending holding register
  always_ff @(posedge clk)
  begin
    if (req_valid && wb_we_i)
    begin
      push_entry_o <= {is_cmd, wb_dat_i[tft_spi_pkg::DATA_W-1:0]};
    end

    if (req_valid)
    begin
      if (!wb_we_i && is_status)
      begin
        wb_dat_o <= {30'd0, tx_idle_i, fifo_full_i};
      end
      else
      begin
        wb_dat_o <= 32'd0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/tft_spi_pkg.sv */
`default_nettype none

package tft_spi_pkg;

  // Register map, word index from wb_adr_i[31:2]
  localparam logic [29:0] REG_STATUS = 30'd0;
  localparam logic [29:0] REG_CMD    = 30'd1;
  localparam logic [29:0] REG_DATA   = 30'd2;

  localparam int DATA_W   = 16;
  localparam int CMD_BITS = 8;           // Commands send the low byte only
  localparam int ENTRY_W  = DATA_W + 1;  // Tag bit on top, 1 for a command

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // Half-period of SCK in clk cycles
  localparam int SCK_DIV   = 4;
  localparam int SCK_CNT_W = $clog2(SCK_DIV);
  localparam logic [SCK_CNT_W-1:0] SCK_LAST = SCK_CNT_W'(SCK_DIV - 1);

  // Transmitter bit counter, also reused for the release hold time
  localparam int TX_CNT_W = $clog2(DATA_W + 1);
  localparam logic [TX_CNT_W-1:0] CMD_LEN  = TX_CNT_W'(CMD_BITS);
  localparam logic [TX_CNT_W-1:0] DATA_LEN = TX_CNT_W'(DATA_W);
  localparam logic [TX_CNT_W-1:0] HOLD_LEN = TX_CNT_W'(SCK_DIV - 2);

  // Transmitter FSM states
  localparam logic [2:0] TX_IDLE    = 3'd0;
  localparam logic [2:0] TX_REQ     = 3'd1;
  localparam logic [2:0] TX_SELECT  = 3'd2;
  localparam logic [2:0] TX_SHIFT   = 3'd3;
  localparam logic [2:0] TX_RELEASE = 3'd4;

endpackage

`default_nettype wire
